// File: texture_pkg.sv
package texture_pkg;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------

	// word address into texture memory
	typedef logic [19:0] addr_t;

	// one texel, one memory word
	typedef logic [15:0] texel_t;

	// width, height or row stride in texels
	typedef logic [9:0] dim_t;

	// --------------------------------------------------
	// block geometry
	// --------------------------------------------------

	localparam int BLK_SIZE_LOG2 = 2;
	localparam int BLK_SIZE = 1 << BLK_SIZE_LOG2;
	localparam int BLK_TEXELS = BLK_SIZE * BLK_SIZE;

	// --------------------------------------------------
	// address queue and copy engine
	// --------------------------------------------------

	localparam int FIFO_DEPTH_LOG2 = 2;

	typedef enum logic [1:0] {
		copy_idle,
		copy_read,
		copy_write
	} copy_state_t;

endpackage

// File: texture_addr_gen.sv
`timescale 1ns/1ps

module texture_addr_gen
	import texture_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  start,
	input  dim_t  width,
	input  dim_t  height,
	input  dim_t  src_stride,
	input  addr_t src_base,
	input  addr_t dst_base,
	output logic  busy,
	output addr_t src_addr,
	output addr_t dst_addr,
	output logic  last,
	output logic  valid,
	input  logic  ready
);

	// whole pipeline advances together
	logic cke;

	dim_t blk_cols;
	dim_t blk_rows;
	addr_t src_blk_step;
	addr_t dst_blk_step;

	assign cke = ready;
	assign blk_cols = width >> BLK_SIZE_LOG2;
	assign blk_rows = height >> BLK_SIZE_LOG2;
	assign src_blk_step = addr_t'(src_stride) << BLK_SIZE_LOG2;
	assign dst_blk_step = addr_t'(blk_cols) * addr_t'(BLK_TEXELS);

	// --------------------------------------------------
	// stage 0: scan counters
	// --------------------------------------------------

	logic [BLK_SIZE_LOG2-1:0] st0_in_x;
	logic st0_in_x_last;
	logic [BLK_SIZE_LOG2-1:0] st0_in_y;
	logic st0_in_y_last;
	dim_t st0_blk_x;
	logic st0_blk_x_last;
	dim_t st0_blk_y;
	logic st0_blk_y_last;

	// blk_y * 4 * stride
	addr_t st0_src_blk_base;
	// in_y * stride
	addr_t st0_src_row_off;
	// blk_y * blocks per row * 16
	addr_t st0_dst_blk_base;

	logic st0_valid;

	logic st0_end_blk;
	logic st0_end_blk_row;
	logic st0_end_scan;

	assign st0_end_blk = st0_in_x_last && st0_in_y_last;
	assign st0_end_blk_row = st0_end_blk && st0_blk_x_last;
	assign st0_end_scan = st0_end_blk_row && st0_blk_y_last;

	always_ff @(posedge clk) begin
		if (!st0_valid) begin
			st0_in_x <= '0;
			st0_in_x_last <= (BLK_SIZE == 1);
			st0_in_y <= '0;
			st0_in_y_last <= (BLK_SIZE == 1);
			st0_blk_x <= '0;
			st0_blk_x_last <= (blk_cols == dim_t'(1));
			st0_blk_y <= '0;
			st0_blk_y_last <= (blk_rows == dim_t'(1));
			st0_src_blk_base <= '0;
			st0_src_row_off <= '0;
			st0_dst_blk_base <= '0;
		end else if (cke) begin
			// column inside the block
			if (st0_in_x_last) begin
				st0_in_x <= '0;
				st0_in_x_last <= (BLK_SIZE == 1);
			end else begin
				st0_in_x <= st0_in_x + 1'b1;
				st0_in_x_last <= (st0_in_x == BLK_SIZE - 2);
			end

			// row inside the block
			if (st0_in_x_last) begin
				if (st0_in_y_last) begin
					st0_in_y <= '0;
					st0_in_y_last <= (BLK_SIZE == 1);
					st0_src_row_off <= '0;
				end else begin
					st0_in_y <= st0_in_y + 1'b1;
					st0_in_y_last <= (st0_in_y == BLK_SIZE - 2);
					st0_src_row_off <= st0_src_row_off + addr_t'(src_stride);
				end
			end

			// block column
			if (st0_end_blk) begin
				if (st0_blk_x_last) begin
					st0_blk_x <= '0;
					st0_blk_x_last <= (blk_cols == dim_t'(1));
				end else begin
					st0_blk_x <= st0_blk_x + 1'b1;
					st0_blk_x_last <= ((st0_blk_x + 1'b1) == (blk_cols - 1'b1));
				end
			end

			// block row, the scan stops after the last one
			if (st0_end_blk_row) begin
				st0_blk_y <= st0_blk_y + 1'b1;
				st0_blk_y_last <= ((st0_blk_y + 1'b1) == (blk_rows - 1'b1));
				st0_src_blk_base <= st0_src_blk_base + src_blk_step;
				st0_dst_blk_base <= st0_dst_blk_base + dst_blk_step;
			end
		end
	end

	// start is taken even when stalled
	always_ff @(posedge clk) begin
		if (reset) begin
			st0_valid <= 1'b0;
		end else if (!st0_valid) begin
			st0_valid <= start;
		end else if (cke && st0_end_scan) begin
			st0_valid <= 1'b0;
		end
	end

	// --------------------------------------------------
	// stage 1 and 2: address sums
	// --------------------------------------------------

	addr_t st1_src_a;
	addr_t st1_src_b;
	addr_t st1_dst_a;
	addr_t st1_dst_b;
	logic st1_last;
	logic st1_valid;

	addr_t st2_src_addr;
	addr_t st2_dst_addr;
	logic st2_last;
	logic st2_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
		end else if (cke) begin
			st1_valid <= st0_valid;
			st2_valid <= st1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cke) begin
			st1_src_a <= src_base + st0_src_blk_base;
			st1_src_b <= st0_src_row_off + addr_t'({st0_blk_x, st0_in_x});
			st1_dst_a <= dst_base + st0_dst_blk_base;
			// block index, row and column pack into the tiled offset
			st1_dst_b <= addr_t'({st0_blk_x, st0_in_y, st0_in_x});
			st1_last <= st0_end_scan;

			st2_src_addr <= st1_src_a + st1_src_b;
			st2_dst_addr <= st1_dst_a + st1_dst_b;
			st2_last <= st1_last;
		end
	end

	assign busy = st0_valid;
	assign src_addr = st2_src_addr;
	assign dst_addr = st2_dst_addr;
	assign last = st2_last;
	assign valid = st2_valid;

endmodule

// File: addr_fifo.sv
`timescale 1ns/1ps

module addr_fifo
	import texture_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  addr_t in_src_addr,
	input  addr_t in_dst_addr,
	input  logic  in_last,
	input  logic  in_valid,
	output logic  in_ready,
	output addr_t out_src_addr,
	output addr_t out_dst_addr,
	output logic  out_last,
	output logic  out_valid,
	input  logic  out_ready
);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	addr_t src_mem [1 << FIFO_DEPTH_LOG2];
	addr_t dst_mem [1 << FIFO_DEPTH_LOG2];
	logic last_mem [1 << FIFO_DEPTH_LOG2];

	// extra msb tells full from empty
	logic [FIFO_DEPTH_LOG2:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2:0] rd_ptr;

	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2])
		&& (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

	assign out_valid = !empty;
	assign pop = out_valid && out_ready;

	// a pop frees the slot in the same cycle
	assign in_ready = !full || out_ready;
	assign push = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			src_mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= in_src_addr;
			dst_mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= in_dst_addr;
			last_mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= in_last;
		end
	end

	// head entry straight from the storage flops
	assign out_src_addr = src_mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
	assign out_dst_addr = dst_mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
	assign out_last = last_mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

endmodule

// File: texture_copy_master.sv
`timescale 1ns/1ps

module texture_copy_master
	import texture_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  addr_t  src_addr,
	input  addr_t  dst_addr,
	input  logic   last,
	input  logic   valid,
	output logic   ready,
	output logic   busy,
	output logic   done,
	output logic   wb_cyc,
	output logic   wb_stb,
	output logic   wb_we,
	output addr_t  wb_adr,
	output texel_t wb_dat_o,
	input  texel_t wb_dat_i,
	input  logic   wb_ack
);

	copy_state_t state;

	// pop the address pair once the write is acked
	assign ready = (state == copy_write) && wb_stb && wb_ack;

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= copy_idle;
			busy <= 1'b0;
			done <= 1'b0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			done <= 1'b0;

			// covers the generator fill as well
			if (start && !busy)
				busy <= 1'b1;

			case (state)
				copy_idle: begin
					if (valid) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= 1'b0;
						state <= copy_read;
					end
				end

				copy_read: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						state <= copy_write;
					end
				end

				copy_write: begin
					// one idle cycle after the read, then the write
					if (!wb_stb) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= 1'b1;
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						state <= copy_idle;
						if (last) begin
							busy <= 1'b0;
							done <= 1'b1;
						end
					end
				end

				default: begin
					state <= copy_idle;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// address and data
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (state == copy_idle && valid)
			wb_adr <= src_addr;
		else if (state == copy_write && !wb_stb)
			wb_adr <= dst_addr;

		// texel held for the write
		if (state == copy_read && wb_ack)
			wb_dat_o <= wb_dat_i;
	end

endmodule

// File: texture_blocker.sv
`timescale 1ns/1ps

module texture_blocker
	import texture_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  dim_t   width,
	input  dim_t   height,
	input  dim_t   src_stride,
	input  addr_t  src_base,
	input  addr_t  dst_base,
	output logic   busy,
	output logic   done,
	output logic   wb_cyc,
	output logic   wb_stb,
	output logic   wb_we,
	output addr_t  wb_adr,
	output texel_t wb_dat_o,
	input  texel_t wb_dat_i,
	input  logic   wb_ack
);

	addr_t gen_src_addr;
	addr_t gen_dst_addr;
	logic gen_last;
	logic gen_valid;
	logic gen_ready;
	logic gen_busy;
	logic gen_start;

	addr_t fifo_src_addr;
	addr_t fifo_dst_addr;
	logic fifo_last;
	logic fifo_valid;
	logic fifo_ready;

	logic copy_busy;

	// no new scan while the engine still drains the last job
	assign gen_start = start & ~copy_busy;
	assign busy = gen_busy | copy_busy;

	// --------------------------------------------------
	// address generator
	// --------------------------------------------------

	texture_addr_gen u_addr_gen (
		.clk        (clk),
		.reset      (reset),
		.start      (gen_start),
		.width      (width),
		.height     (height),
		.src_stride (src_stride),
		.src_base   (src_base),
		.dst_base   (dst_base),
		.busy       (gen_busy),
		.src_addr   (gen_src_addr),
		.dst_addr   (gen_dst_addr),
		.last       (gen_last),
		.valid      (gen_valid),
		.ready      (gen_ready)
	);

	addr_fifo u_fifo (
		.clk          (clk),
		.reset        (reset),
		.in_src_addr  (gen_src_addr),
		.in_dst_addr  (gen_dst_addr),
		.in_last      (gen_last),
		.in_valid     (gen_valid),
		.in_ready     (gen_ready),
		.out_src_addr (fifo_src_addr),
		.out_dst_addr (fifo_dst_addr),
		.out_last     (fifo_last),
		.out_valid    (fifo_valid),
		.out_ready    (fifo_ready)
	);

	// --------------------------------------------------
	// copy engine on the memory port
	// --------------------------------------------------

	texture_copy_master u_copy (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.src_addr (fifo_src_addr),
		.dst_addr (fifo_dst_addr),
		.last     (fifo_last),
		.valid    (fifo_valid),
		.ready    (fifo_ready),
		.busy     (copy_busy),
		.done     (done),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_o (wb_dat_o),
		.wb_dat_i (wb_dat_i),
		.wb_ack   (wb_ack)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// held over two rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
	end

endmodule

// File: texture_blocker_checker.sv
`timescale 1ns/1ps

module texture_blocker_checker
	import texture_pkg::*;
(
	input logic   clk,
	input logic   reset,
	input logic   busy,
	input logic   done,
	input logic   wb_cyc,
	input logic   wb_stb,
	input logic   wb_we,
	input addr_t  wb_adr,
	input texel_t wb_dat_o,
	input logic   wb_ack
);

	int fail_count = 0;

	copy_state_t bus_phase;
	logic have_texel;

	// phase as seen on the bus
	always_comb begin
		if (!wb_cyc)
			bus_phase = copy_idle;
		else if (wb_we)
			bus_phase = copy_write;
		else
			bus_phase = copy_read;
	end

	// set by a read ack, cleared by a write ack
	always_ff @(posedge clk) begin
		if (reset)
			have_texel <= 1'b0;
		else if (wb_stb && wb_ack)
			have_texel <= (bus_phase == copy_read);
	end

	// --------------------------------------------------
	// control outputs
	// --------------------------------------------------

	reset_idle: assert property (@(posedge clk)
		reset |=> !busy && !done && !wb_cyc && !wb_stb)
	else begin
		fail_count++;
		$error("busy, done or bus active right after reset");
	end

	done_single: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
	else begin
		fail_count++;
		$error("done high for more than one cycle");
	end

	done_busy_fall: assert property (@(posedge clk) disable iff (reset)
		done |-> !busy && $past(busy))
	else begin
		fail_count++;
		$error("done does not line up with busy falling");
	end

	// --------------------------------------------------
	// Wishbone port
	// --------------------------------------------------

	stb_cyc: assert property (@(posedge clk) disable iff (reset)
		wb_stb |-> wb_cyc)
	else begin
		fail_count++;
		$error("stb high without cyc");
	end

	stb_hold: assert property (@(posedge clk) disable iff (reset)
		wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_we) && $stable(wb_adr)
			&& (!wb_we || $stable(wb_dat_o)))
	else begin
		fail_count++;
		$error("bus cycle changed before its ack");
	end

	write_after_read: assert property (@(posedge clk) disable iff (reset)
		bus_phase == copy_write |-> have_texel)
	else begin
		fail_count++;
		$error("write cycle without a texel read first");
	end

endmodule

// File: tb_texture_blocker.sv
`timescale 1ns/1ps

module tb_texture_blocker
	import texture_pkg::*;
();

	localparam int MEM_WORDS = 4096;
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk;
	logic reset;
	logic start;
	dim_t width;
	dim_t height;
	dim_t src_stride;
	addr_t src_base;
	addr_t dst_base;
	logic busy;
	logic done;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	addr_t wb_adr;
	texel_t wb_dat_o;
	texel_t wb_dat_i;
	logic wb_ack;

	texel_t mem [MEM_WORDS];
	bit written [MEM_WORDS];
	addr_t area_lo;
	addr_t area_hi;
	int write_count;
	int done_count;
	int ack_wait;
	int errors;
	bit aborted;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	texture_blocker u_dut (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.width      (width),
		.height     (height),
		.src_stride (src_stride),
		.src_base   (src_base),
		.dst_base   (dst_base),
		.busy       (busy),
		.done       (done),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_o   (wb_dat_o),
		.wb_dat_i   (wb_dat_i),
		.wb_ack     (wb_ack)
	);

	bind texture_blocker texture_blocker_checker u_checker (
		.clk      (clk),
		.reset    (reset),
		.busy     (busy),
		.done     (done),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack)
	);

	task automatic expect_value(input string name, input int got, input int expected);
		assert (got == expected) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		aborted = 1'b1;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	// only the current job's destination area may be written, each word once
	task automatic store_word(input addr_t adr, input texel_t data);
		assert (adr >= area_lo && adr < area_hi) else begin
			errors++;
			$display("write outside the destination area at %0t, address %h", $time, adr);
		end
		assert (!written[adr[11:0]]) else begin
			errors++;
			$display("second write to address %h at %0t", adr, $time);
		end
		written[adr[11:0]] = 1'b1;
		mem[adr[11:0]] = data;
		write_count++;
	endtask

	// --------------------------------------------------
	// Wishbone memory model, ack after 0 to 3 wait cycles
	// --------------------------------------------------

	always @(negedge clk) begin
		if (wb_ack) begin
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (ack_wait > 0) begin
				ack_wait <= ack_wait - 1;
			end else begin
				ack_wait <= $urandom % 4;
				wb_ack <= 1'b1;
				if (wb_we)
					store_word(wb_adr, wb_dat_o);
				else
					wb_dat_i <= mem[wb_adr[11:0]];
			end
		end
	end

	always @(negedge clk) begin
		if (done)
			done_count <= done_count + 1;
	end

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (reset && cycles < 10);
		if (reset)
			report_timeout("reset release");
	endtask

	task automatic run_job(input dim_t w, input dim_t h, input dim_t stride,
		input addr_t src, input addr_t dst, input bit restart);
		int n;
		int x;
		int y;
		int cycles;
		int first_done;
		addr_t s;
		addr_t d;
		addr_t last_dst;
		n = w * h;
		for (int i = 0; i < n; i++) begin
			mem[dst + i] = '0;
			written[dst + i] = 1'b0;
		end
		area_lo = dst;
		area_hi = dst + addr_t'(n);
		last_dst = dst + addr_t'(n - 1);
		write_count = 0;
		first_done = done_count;

		@(negedge clk);
		width = w;
		height = h;
		src_stride = stride;
		src_base = src;
		dst_base = dst;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;

		// a second start while the final texel is written and the scan is over
		if (restart) begin
			cycles = 0;
			while (!(wb_cyc && wb_we && wb_adr == last_dst) && cycles < TIMEOUT_CYCLES) begin
				@(negedge clk);
				cycles++;
			end
			if (!(wb_cyc && wb_we && wb_adr == last_dst)) begin
				report_timeout("the last write");
				return;
			end
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end

		cycles = 0;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			expect_value("busy", busy, 1);
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			report_timeout("done");
			return;
		end
		expect_value("busy", busy, 0);

		// quiet afterwards
		repeat (12) begin
			@(negedge clk);
			expect_value("busy", busy, 0);
		end
		expect_value("done pulses", done_count - first_done, 1);
		expect_value("write count", write_count, n);

		for (y = 0; y < h; y++) begin
			for (x = 0; x < w; x++) begin
				s = src + y * stride + x;
				d = dst + ((y >> BLK_SIZE_LOG2) * (w >> BLK_SIZE_LOG2) + (x >> BLK_SIZE_LOG2))
					* BLK_TEXELS + (y % BLK_SIZE) * BLK_SIZE + x % BLK_SIZE;
				expect_value($sformatf("mem[%h]", d), mem[d[11:0]], s[15:0] ^ 16'h5a5a);
			end
		end
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = u_dut.u_checker.fail_count;
		$display("errors: %0d testbench checks, %0d assertions", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(32'h95fc9e3c));
		start = 1'b0;
		width = '0;
		height = '0;
		src_stride = '0;
		src_base = '0;
		dst_base = '0;
		wb_dat_i = '0;
		wb_ack = 1'b0;
		area_lo = '0;
		area_hi = '0;
		write_count = 0;
		done_count = 0;
		ack_wait = 0;
		errors = 0;
		aborted = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = texel_t'(i) ^ 16'h5a5a;
			written[i] = 1'b0;
		end

		wait_reset_release();
		if (!aborted) begin
			expect_value("busy", busy, 0);
			expect_value("done", done, 0);
			expect_value("wb_cyc", wb_cyc, 0);
		end

		// single block, then a padded source stride
		if (!aborted)
			run_job(10'd4, 10'd4, 10'd4, 20'h00010, 20'h00800, 1'b0);
		if (!aborted)
			run_job(10'd16, 10'd8, 10'd20, 20'h00100, 20'h00900, 1'b0);
		if (!aborted)
			run_job(10'd8, 10'd8, 10'd8, 20'h00300, 20'h00a00, 1'b1);
		// same source, two targets
		if (!aborted)
			run_job(10'd8, 10'd4, 10'd12, 20'h00400, 20'h00b00, 1'b0);
		if (!aborted)
			run_job(10'd8, 10'd4, 10'd12, 20'h00400, 20'h00c00, 1'b0);

		finish_run();
	end

endmodule

// File: sources.f
texture_pkg.sv
texture_addr_gen.sv
addr_fifo.sv
texture_copy_master.sv
texture_blocker.sv
tb_clock_gen.sv
texture_blocker_checker.sv
tb_texture_blocker.sv

// File: Makefile
SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_texture_blocker: sources.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_texture_blocker -f sources.f

run: obj_dir/Vtb_texture_blocker
	-./obj_dir/Vtb_texture_blocker +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@grep -qx "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
